/* all.f */
design/shtp_pkg.sv
design/shtp_delay_timer.sv
design/shtp_cmd_rom.sv
design/shtp_report_parser.sv
design/shtp_sequencer.sv
design/bno085_hub.sv
test/tb_clock_gen.sv
test/tb_bno085_hub.sv

/* design/bno085_hub.sv */
`timescale 1ns/100ps
`default_nettype none

module bno085_hub #(
    parameter int unsigned RESET_WAIT  = shtp_pkg::DEF_RESET_WAIT,
    parameter int unsigned WAKE_HOLD   = shtp_pkg::DEF_WAKE_HOLD,
    parameter int unsigned INT_TIMEOUT = shtp_pkg::DEF_INT_TIMEOUT,
    parameter int unsigned CMD_GAP     = shtp_pkg::DEF_CMD_GAP
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               int_n,
    input  shtp_pkg::spi_rsp_t spi_rsp,
    output shtp_pkg::spi_req_t spi_req,
    output logic               cs_n,
    output logic               ps0_wake,
    output logic               quat_valid,
    output logic               gyro_valid,
    output shtp_pkg::sample_u  sample,
    output logic               initialized,
    output logic               error
);

    import shtp_pkg::*;

    logic               expired;
    logic               load;
    logic [TIMER_W-1:0] load_count;
    byte_t              cmd_byte;
    logic               cmd_last_byte;
    logic               cmd_last_cmd;
    logic               byte_adv;
    logic               cmd_adv;
    logic               frame_start;
    logic               rx_strobe;
    byte_t              rx_data;
    frame_stat_t        frame_stat;

    // ========================================================================
    // Control path
    // ========================================================================
    shtp_sequencer #(
        .RESET_WAIT  (RESET_WAIT),
        .WAKE_HOLD   (WAKE_HOLD),
        .INT_TIMEOUT (INT_TIMEOUT),
        .CMD_GAP     (CMD_GAP)
    ) u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .int_n         (int_n),
        .spi_rsp       (spi_rsp),
        .expired       (expired),
        .cmd_byte      (cmd_byte),
        .cmd_last_byte (cmd_last_byte),
        .cmd_last_cmd  (cmd_last_cmd),
        .frame_stat    (frame_stat),
        .spi_req       (spi_req),
        .cs_n          (cs_n),
        .ps0_wake      (ps0_wake),
        .load          (load),
        .load_count    (load_count),
        .byte_adv      (byte_adv),
        .cmd_adv       (cmd_adv),
        .frame_start   (frame_start),
        .rx_strobe     (rx_strobe),
        .rx_data       (rx_data),
        .initialized   (initialized),
        .error         (error)
    );

    shtp_delay_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_count (load_count),
        .expired    (expired)
    );

    shtp_cmd_rom u_rom (
        .clk           (clk),
        .rst_n         (rst_n),
        .byte_adv      (byte_adv),
        .cmd_adv       (cmd_adv),
        .cmd_byte      (cmd_byte),
        .cmd_last_byte (cmd_last_byte),
        .cmd_last_cmd  (cmd_last_cmd)
    );

    // Receive path
    shtp_report_parser u_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .rx_strobe   (rx_strobe),
        .rx_data     (rx_data),
        .frame_stat  (frame_stat),
        .quat_valid  (quat_valid),
        .gyro_valid  (gyro_valid),
        .sample      (sample)
    );

endmodule

`default_nettype wire

/* design/shtp_cmd_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module shtp_cmd_rom (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            byte_adv,       // Byte sent
    input  logic            cmd_adv,        // Move to next command
    output shtp_pkg::byte_t cmd_byte,
    output logic            cmd_last_byte,
    output logic            cmd_last_cmd
);

    import shtp_pkg::*;

    localparam int CMD_W = $clog2(NUM_CMDS);

    logic [CMD_W-1:0] cmd_idx;
    logic [4:0]       byte_idx;   // Commands are at most 17 bytes
    byte_t            cmd_len;

    // ========================================================================
    // Command table, all on channel 2
    // ========================================================================
    // 0: 05 00 02 00 F9                  Product ID request
    // 1: 11 00 02 01 FD 05 00 00 00 20 4E 00 00 00 00 00 00
    // 2: as 1 with sequence 02 and report 02
    function automatic byte_t rom_byte(input logic [CMD_W-1:0] cmd, input logic [4:0] idx);
        byte_t b;
        b = 8'h00;                                        // Padding and zero fields
        case (idx)
            5'd0:  b = (cmd == '0) ? 8'h05 : 8'h11;       // Length LSB
            5'd2:  b = 8'h02;                             // Control channel
            5'd3:  b = 8'(cmd);                           // Sequence follows index
            5'd4:  b = (cmd == '0) ? 8'hF9 : 8'hFD;       // Prod ID req / set feature
            5'd5:  b = (cmd == CMD_W'(1)) ? RID_ROTATION : RID_GYRO;
            5'd9:  b = 8'h20;                             // 20000 us interval
            5'd10: b = 8'h4E;
            default: b = 8'h00;
        endcase
        return b;
    endfunction

    assign cmd_byte = rom_byte(cmd_idx, byte_idx);
    assign cmd_len  = rom_byte(cmd_idx, 5'd0);            // Length from header byte

    assign cmd_last_byte = ({3'b000, byte_idx} == cmd_len - 8'd1);
    assign cmd_last_cmd  = (cmd_idx == CMD_W'(NUM_CMDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_idx  <= '0;
            byte_idx <= '0;
        end else begin
            if (byte_adv) begin
                byte_idx <= cmd_last_byte ? 5'd0 : byte_idx + 5'd1;   // Wrap at end
            end
            if (cmd_adv && !cmd_last_cmd) begin
                cmd_idx <= cmd_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/shtp_delay_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module shtp_delay_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,        // Restart with load_count
    input  logic [shtp_pkg::TIMER_W-1:0] load_count,
    output logic                         expired      // Level, held at zero
);

    import shtp_pkg::*;

    logic [TIMER_W-1:0] count;

    // Down-counter, parks at zero until the next load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired = (count == '0);

endmodule

`default_nettype wire

/* design/shtp_pkg.sv */
`default_nettype none

package shtp_pkg;

    // ========================================================================
    // Basic types
    // ========================================================================
    typedef logic [7:0]        byte_t;     // One SPI data byte
    typedef logic signed [15:0] word16_t;  // Q-point sensor field

    // Controller to SPI master
    typedef struct packed {
        logic  start;    // Held until done
        byte_t tx_data;  // Stable while start is high
    } spi_req_t;

    // SPI master back to controller
    typedef struct packed {
        logic  done;     // Single cycle pulse
        byte_t rx_data;  // Valid with done
    } spi_rsp_t;

    // Four words in receive order, first word in the top bits
    typedef union packed {
        struct packed {
            word16_t i;
            word16_t j;
            word16_t k;
            word16_t real_part;
        } quat_view;
        struct packed {
            word16_t x;
            word16_t y;
            word16_t z;
            word16_t unused;   // Not written by gyro reports
        } gyro_view;
    } sample_u;

    // Parser status for the byte in the current strobe
    typedef struct packed {
        logic hdr_done;  // 4th header byte
        logic len_ok;    // Header length accepted
        logic last;      // Final byte of packet
    } frame_stat_t;

    // ========================================================================
    // SHTP constants
    // ========================================================================
    localparam byte_t CH_REPORTS   = 8'd3;   // Input sensor reports
    localparam byte_t CH_GYRO_RV   = 8'd5;   // Gyro integrated RV channel
    localparam byte_t RID_ROTATION = 8'h05;
    localparam byte_t RID_GYRO     = 8'h02;  // Calibrated gyroscope

    localparam int SHTP_HDR_LEN = 4;
    localparam int SHTP_MAX_LEN = 32766;

    // Delay counter and default waits in clock cycles
    localparam int          TIMER_W         = 19;
    localparam int unsigned DEF_RESET_WAIT  = 300000;
    localparam int unsigned DEF_WAKE_HOLD   = 450;    // PS0 low pulse
    localparam int unsigned DEF_INT_TIMEOUT = 150000;
    localparam int unsigned DEF_CMD_GAP     = 30000;

    localparam int NUM_CMDS = 3;  // Product ID, rotation vector, gyro

endpackage

`default_nettype wire

/* design/shtp_report_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module shtp_report_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_start,  // cs_n lowered for a read
    input  logic                  rx_strobe,    // One received byte
    input  shtp_pkg::byte_t       rx_data,
    output shtp_pkg::frame_stat_t frame_stat,
    output logic                  quat_valid,
    output logic                  gyro_valid,
    output shtp_pkg::sample_u     sample
);

    import shtp_pkg::*;

    logic [15:0]      byte_cnt;     // Position in frame, header included
    logic [15:0]      pay_idx;      // Position in payload
    logic [14:0]      pkt_len;      // Continuation bit dropped
    byte_t            channel;
    byte_t            report_id;    // Zero unless channel accepted
    byte_t            lsb;          // Low byte of the pending field
    logic [3:0][15:0] words;        // Word 3 received first
    logic [1:0]       word_sel;
    logic             ch_ok;
    logic             is_rot;
    logic             is_gyro;
    logic             field_ok;

    assign pay_idx  = byte_cnt - 16'(SHTP_HDR_LEN);
    assign ch_ok    = (channel == CH_REPORTS) || (channel == CH_GYRO_RV);
    assign is_rot   = (report_id == RID_ROTATION);
    assign is_gyro  = (report_id == RID_GYRO);
    assign word_sel = 2'(pay_idx[3:1] - 3'd2);        // Fields start at payload byte 4

    // Field bytes: 4..11 for quaternion, 4..9 for gyro
    assign field_ok = (byte_cnt >= 16'(SHTP_HDR_LEN + 4)) &&
                      ((is_rot && pay_idx <= 16'd11) || (is_gyro && pay_idx <= 16'd9));

    // Status for the byte now on rx_data
    always_comb begin
        frame_stat.hdr_done = (byte_cnt == 16'(SHTP_HDR_LEN - 1));
        frame_stat.len_ok   = (pkt_len > 15'(SHTP_HDR_LEN)) &&
                              (pkt_len <= 15'(SHTP_MAX_LEN));
        frame_stat.last     = (byte_cnt >= 16'(SHTP_HDR_LEN)) &&
                              (byte_cnt == {1'b0, pkt_len} - 16'd1);
    end

    // ========================================================================
    // Header capture and valid pulses
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt   <= '0;
            pkt_len    <= '0;
            channel    <= '0;
            report_id  <= '0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            quat_valid <= rx_strobe && field_ok && is_rot && (pay_idx == 16'd11);
            gyro_valid <= rx_strobe && field_ok && is_gyro && (pay_idx == 16'd9);
            if (frame_start) begin
                byte_cnt <= '0;
            end else if (rx_strobe) begin
                byte_cnt <= byte_cnt + 16'd1;
                case (byte_cnt)
                    16'd0: pkt_len[7:0]  <= rx_data;
                    16'd1: pkt_len[14:8] <= rx_data[6:0];          // Bit 15 masked
                    16'd2: channel       <= rx_data;
                    16'd4: report_id     <= ch_ok ? rx_data : 8'h00;
                    default: ;                                     // Seq, status, delay
                endcase
            end
        end
    end

    // Little-endian field assembly, LSB held until its MSB arrives
    always_ff @(posedge clk) begin
        if (rx_strobe && field_ok) begin
            if (!pay_idx[0]) begin
                lsb <= rx_data;
            end else begin
                words[3 - word_sel] <= {rx_data, lsb};
            end
        end
    end

    assign sample = words;

endmodule

`default_nettype wire

/* design/shtp_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module shtp_sequencer #(
    parameter int unsigned RESET_WAIT  = shtp_pkg::DEF_RESET_WAIT,
    parameter int unsigned WAKE_HOLD   = shtp_pkg::DEF_WAKE_HOLD,
    parameter int unsigned INT_TIMEOUT = shtp_pkg::DEF_INT_TIMEOUT,
    parameter int unsigned CMD_GAP     = shtp_pkg::DEF_CMD_GAP
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         int_n,          // Async, active low
    input  shtp_pkg::spi_rsp_t           spi_rsp,
    input  logic                         expired,
    input  shtp_pkg::byte_t              cmd_byte,
    input  logic                         cmd_last_byte,
    input  logic                         cmd_last_cmd,
    input  shtp_pkg::frame_stat_t        frame_stat,
    output shtp_pkg::spi_req_t           spi_req,
    output logic                         cs_n,
    output logic                         ps0_wake,       // Active low
    output logic                         load,
    output logic [shtp_pkg::TIMER_W-1:0] load_count,
    output logic                         byte_adv,
    output logic                         cmd_adv,
    output logic                         frame_start,
    output logic                         rx_strobe,
    output shtp_pkg::byte_t              rx_data,
    output logic                         initialized,
    output logic                         error
);

    import shtp_pkg::*;

    typedef enum logic [3:0] {
        ST_BOOT,        // Arm reset wait
        ST_RST_WAIT,
        ST_WAKE,        // PS0 held low
        ST_WAIT_INT,
        ST_CMD_XFER,
        ST_CMD_GAP,
        ST_READY,       // Initialized, waiting for INT
        ST_RD_XFER,
        ST_ERROR
    } state_t;

    state_t state;
    logic   int_meta;
    logic   int_sync;
    logic   int_asserted;
    logic   timer_done;
    logic   rd_end;

    // INT synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    assign int_asserted = !int_sync;
    assign timer_done   = expired && !load;   // Timer reloads one cycle after load
    assign rd_end       = frame_stat.last || (frame_stat.hdr_done && !frame_stat.len_ok);

    // Strobes to ROM and parser
    assign byte_adv    = (state == ST_CMD_XFER) && spi_rsp.done;
    assign cmd_adv     = (state == ST_CMD_GAP) && timer_done && !cmd_last_cmd;
    assign frame_start = (state == ST_READY) && int_asserted;
    assign rx_strobe   = (state == ST_RD_XFER) && spi_rsp.done;
    assign rx_data     = spi_rsp.rx_data;

    // ========================================================================
    // Init and read FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_BOOT;
            spi_req     <= '0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            load        <= 1'b0;
            load_count  <= '0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            load <= 1'b0;                                    // Single cycle pulse
            case (state)
                ST_BOOT: begin
                    load       <= 1'b1;
                    load_count <= TIMER_W'(RESET_WAIT);
                    state      <= ST_RST_WAIT;
                end
                ST_RST_WAIT: if (timer_done) begin
                    if (int_asserted) begin                  // Sensor already asked
                        cs_n  <= 1'b0;
                        state <= ST_CMD_XFER;
                    end else begin
                        ps0_wake   <= 1'b0;
                        load       <= 1'b1;
                        load_count <= TIMER_W'(WAKE_HOLD);
                        state      <= ST_WAKE;
                    end
                end
                ST_WAKE: if (timer_done) begin
                    ps0_wake   <= 1'b1;
                    load       <= 1'b1;
                    load_count <= TIMER_W'(INT_TIMEOUT);
                    state      <= ST_WAIT_INT;
                end
                ST_WAIT_INT: begin
                    if (int_asserted) begin
                        cs_n  <= 1'b0;
                        state <= ST_CMD_XFER;
                    end else if (timer_done) begin
                        error <= 1'b1;                       // Sticky until reset
                        state <= ST_ERROR;
                    end
                end
                ST_CMD_XFER, ST_RD_XFER: begin
                    if (!spi_req.start) begin                // Idle one cycle, then start
                        spi_req.start   <= 1'b1;
                        spi_req.tx_data <= (state == ST_CMD_XFER) ? cmd_byte : 8'h00;
                    end else if (spi_rsp.done) begin
                        spi_req.start <= 1'b0;
                        if (state == ST_CMD_XFER && cmd_last_byte) begin
                            cs_n       <= 1'b1;
                            load       <= 1'b1;
                            load_count <= TIMER_W'(CMD_GAP);
                            state      <= ST_CMD_GAP;
                        end else if (state == ST_RD_XFER && rd_end) begin
                            cs_n  <= 1'b1;                   // Bad length or last byte
                            state <= ST_READY;
                        end
                    end
                end
                ST_CMD_GAP: if (timer_done) begin
                    if (cmd_last_cmd) begin
                        initialized <= 1'b1;
                        state       <= ST_READY;
                    end else begin                           // Wake for next command
                        ps0_wake   <= 1'b0;
                        load       <= 1'b1;
                        load_count <= TIMER_W'(WAKE_HOLD);
                        state      <= ST_WAKE;
                    end
                end
                ST_READY: if (int_asserted) begin
                    cs_n  <= 1'b0;
                    state <= ST_RD_XFER;
                end
                ST_ERROR: state <= ST_ERROR;                 // cs_n stays high
                default:  state <= ST_BOOT;
            endcase
        end
    end

endmodule

`default_nettype wire

/* test/tb_bno085_hub.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_bno085_hub;

    import shtp_pkg::*;

    localparam int WAIT_LIMIT = 2000;    // Cycles per wait
    localparam int SEL_RST_N  = 0;       // Signal selectors for await_level
    localparam int SEL_CS_N   = 1;
    localparam int SEL_PS0    = 2;
    localparam int SEL_INIT   = 3;
    localparam int SEL_ERROR  = 4;

    logic     clk;
    logic     rst_n;
    logic     rerun;
    logic     int_n;
    spi_req_t spi_req;
    spi_rsp_t spi_rsp;
    logic     cs_n;
    logic     ps0_wake;
    logic     quat_valid;
    logic     gyro_valid;
    sample_u  sample;
    logic     initialized;
    logic     error;

    byte_t    rx_q[$];                   // Bytes the sensor shifts out
    byte_t    tx_log[$];                 // Bytes seen by the SPI master
    logic     cs_log[$];                 // cs_n at each done
    byte_t    pkt[$];                    // Packet under test
    int       pkt_pos;                   // Next byte index in the packet
    int       rsp_pos;                   // Index of the byte on rx_data
    logic     prev_done = 1'b0;
    int       prev_pos  = 0;
    int       quat_cnt  = 0;
    int       gyro_cnt  = 0;
    sample_u  got_sample;                // Sample seen with the valid pulse
    sample_u  exp_sample;

    tb_clock_gen clk_gen (
        .rerun (rerun),
        .clk   (clk),
        .rst_n (rst_n)
    );

    bno085_hub #(
        .RESET_WAIT  (20),
        .WAKE_HOLD   (5),
        .INT_TIMEOUT (50),
        .CMD_GAP     (10)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .int_n       (int_n),
        .spi_rsp     (spi_rsp),
        .spi_req     (spi_req),
        .cs_n        (cs_n),
        .ps0_wake    (ps0_wake),
        .quat_valid  (quat_valid),
        .gyro_valid  (gyro_valid),
        .sample      (sample),
        .initialized (initialized),
        .error       (error)
    );

    // ========================================================================
    // Failure reporting and compares
    // ========================================================================
    task automatic stop_with_error(input string what);
        $display("%s (time %0t)", what, $time);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            stop_with_error("Byte mismatch");
        end
    endtask

    task automatic check_sample(input string name, input sample_u got, input sample_u exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_error("Sample mismatch");
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_with_error("Control level mismatch");
        end
    endtask

    task automatic count_equals(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_with_error("Count mismatch");
        end
    endtask

    // Falling-edge poll of one control output, bounded by limit
    task automatic await_level(input string name, input int sel, input logic level,
                               input int limit);
        logic now;
        int   cycles;
        cycles = 0;
        now    = ~level;
        while (now !== level) begin
            if (cycles == limit) begin
                stop_with_error($sformatf("Timed out waiting for %s to go %b", name, level));
            end
            @(negedge clk);
            cycles++;
            case (sel)
                SEL_RST_N: now = rst_n;
                SEL_CS_N:  now = cs_n;
                SEL_PS0:   now = ps0_wake;
                SEL_INIT:  now = initialized;
                default:   now = error;
            endcase
        end
    endtask

    task automatic check_idle();
        expect_level("cs_n", cs_n, 1'b1);
        expect_level("ps0_wake", ps0_wake, 1'b1);
        expect_level("spi_req.start", spi_req.start, 1'b0);
        expect_level("initialized", initialized, 1'b0);
        expect_level("error", error, 1'b0);
        expect_level("quat_valid", quat_valid, 1'b0);
        expect_level("gyro_valid", gyro_valid, 1'b0);
    endtask

    // ========================================================================
    // Reference functions
    // ========================================================================
    // Byte n of the 39-byte init stream
    function automatic byte_t cmd_ref(input int n);
        byte_t prod_id [5];
        byte_t set_feat [17];
        int    k;
        byte_t b;
        prod_id  = '{8'h05, 8'h00, 8'h02, 8'h00, 8'hF9};
        set_feat = '{8'h11, 8'h00, 8'h02, 8'h01, 8'hFD, 8'h05, 8'h00, 8'h00, 8'h00,
                     8'h20, 8'h4E, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        if (n < 5) begin
            b = prod_id[n];
        end else begin
            k = (n - 5) % 17;
            b = set_feat[k];
            if (n >= 22 && (k == 3 || k == 5)) begin
                b = 8'h02;               // Sequence 2, gyro report
            end
        end
        return b;
    endfunction

    // Fields are LSB first from payload byte 4; gyro leaves the 4th word alone
    function automatic sample_u sample_ref(input byte_t p[$], input sample_u prev);
        sample_u s;
        s = prev;
        if (p[4] == RID_ROTATION) begin
            s.quat_view.i         = {p[9], p[8]};
            s.quat_view.j         = {p[11], p[10]};
            s.quat_view.k         = {p[13], p[12]};
            s.quat_view.real_part = {p[15], p[14]};
        end else begin
            s.gyro_view.x = {p[9], p[8]};
            s.gyro_view.y = {p[11], p[10]};
            s.gyro_view.z = {p[13], p[12]};
        end
        return s;
    endfunction

    // ========================================================================
    // SPI master and sensor models
    // ========================================================================
    initial begin : spi_master
        int dly;
        spi_rsp = '0;
        forever begin
            @(negedge clk);
            if (rst_n && spi_req.start) begin
                dly = $urandom_range(4, 1);
                repeat (dly) @(negedge clk);
                spi_rsp.rx_data = (rx_q.size() > 0) ? rx_q.pop_front() : 8'h00;
                spi_rsp.done    = 1'b1;  // One cycle only
                rsp_pos         = pkt_pos;
                pkt_pos         = pkt_pos + 1;
                tx_log.push_back(spi_req.tx_data);
                cs_log.push_back(cs_n);
                @(negedge clk);
                spi_rsp = '0;
            end
        end
    end

    // Counts valid pulses and checks they follow the final field byte's done
    always @(posedge clk) begin
        if (quat_valid) begin
            if (!prev_done || prev_pos != 15) begin
                stop_with_error("quat_valid did not follow the done of payload byte 11");
            end
            quat_cnt   = quat_cnt + 1;
            got_sample = sample;
        end
        if (gyro_valid) begin
            if (!prev_done || prev_pos != 13) begin
                stop_with_error("gyro_valid did not follow the done of payload byte 9");
            end
            gyro_cnt   = gyro_cnt + 1;
            got_sample = sample;
        end
        prev_done = spi_rsp.done;        // Handshake of this cycle, seen at the next edge
        prev_pos  = rsp_pos;
    end

    task automatic build_packet(input byte_t chan, input byte_t rid, input int len);
        int n;
        pkt.delete();
        pkt.push_back(8'(len));          // Length LSB
        pkt.push_back(8'(len >> 8));
        pkt.push_back(chan);
        pkt.push_back(8'($urandom));     // Header sequence
        for (n = 4; n < len; n++) begin
            pkt.push_back(8'($urandom));
        end
        if (len > 4) begin
            pkt[4] = rid;
        end
    endtask

    // Sensor raises INT, drops it on chip select, master drains the packet
    task automatic run_packet(input int quat_exp, input int gyro_exp);
        int q0;
        int g0;
        q0 = quat_cnt;
        g0 = gyro_cnt;
        foreach (pkt[n]) begin
            rx_q.push_back(pkt[n]);
        end
        pkt_pos = 0;
        int_n   = 1'b0;
        await_level("cs_n", SEL_CS_N, 1'b0, WAIT_LIMIT);
        int_n = 1'b1;
        await_level("cs_n", SEL_CS_N, 1'b1, WAIT_LIMIT);
        repeat (3) @(negedge clk);       // Let the last pulse register
        count_equals("quat_valid pulses", quat_cnt - q0, quat_exp);
        count_equals("gyro_valid pulses", gyro_cnt - g0, gyro_exp);
        count_equals("unread packet bytes", rx_q.size(), 0);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin : main
        void'($urandom(79));
        rerun     = 1'b0;
        int_n     = 1'b1;
        pkt_pos   = 0;
        rsp_pos   = 0;

        // Idle outputs in reset and before any INT
        @(negedge clk);
        check_idle();
        await_level("rst_n", SEL_RST_N, 1'b1, 100);
        repeat (10) begin
            @(negedge clk);
            check_idle();
        end

        // Init, each PS0 wake answered by INT
        repeat (NUM_CMDS) begin
            await_level("ps0_wake", SEL_PS0, 1'b0, WAIT_LIMIT);
            int_n = 1'b0;
            await_level("cs_n", SEL_CS_N, 1'b0, WAIT_LIMIT);
            int_n = 1'b1;
            expect_level("initialized", initialized, 1'b0);
            await_level("cs_n", SEL_CS_N, 1'b1, WAIT_LIMIT);
        end
        expect_level("initialized", initialized, 1'b0);   // Still in last gap
        await_level("initialized", SEL_INIT, 1'b1, WAIT_LIMIT);
        count_equals("init byte count", tx_log.size(), 39);
        foreach (tx_log[n]) begin
            check_byte($sformatf("tx_data[%0d]", n), tx_log[n], cmd_ref(n));
            expect_level("cs_n during command", cs_log[n], 1'b0);
        end

        // Rotation vector on channel 3 with bit 15 of the length set
        build_packet(CH_REPORTS, RID_ROTATION, 18);
        pkt[1]     = pkt[1] | 8'h80;
        exp_sample = sample_ref(pkt, exp_sample);
        run_packet(1, 0);
        check_sample("sample at quat_valid", got_sample, exp_sample);
        check_sample("sample", sample, exp_sample);

        // Gyroscope on channel 5
        build_packet(CH_GYRO_RV, RID_GYRO, 14);
        exp_sample = sample_ref(pkt, exp_sample);
        run_packet(0, 1);
        check_sample("sample at gyro_valid", got_sample, exp_sample);

        // Wrong channel, then a header-only length
        build_packet(8'd2, RID_ROTATION, 18);
        run_packet(0, 0);
        build_packet(CH_REPORTS, RID_ROTATION, 4);
        run_packet(0, 0);
        check_sample("sample after rejected packets", sample, exp_sample);

        // Good packet still parsed afterwards
        build_packet(CH_REPORTS, RID_GYRO, 14);
        exp_sample = sample_ref(pkt, exp_sample);
        run_packet(0, 1);
        check_sample("sample at gyro_valid", got_sample, exp_sample);
        expect_level("initialized", initialized, 1'b1);

        // Fresh reset, sensor never answers
        rerun = 1'b1;
        await_level("rst_n", SEL_RST_N, 1'b0, 10);
        rerun = 1'b0;
        await_level("rst_n", SEL_RST_N, 1'b1, 100);
        expect_level("error", error, 1'b0);
        await_level("error", SEL_ERROR, 1'b1, WAIT_LIMIT);
        repeat (20) begin
            @(negedge clk);
            expect_level("error", error, 1'b1);            // Sticky
            expect_level("initialized", initialized, 1'b0);
            expect_level("cs_n", cs_n, 1'b1);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,     // 20 ns clock
    parameter int RESET_CYCLES = 16
) (
    input  logic rerun,                  // Rising edge starts another reset
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            @(posedge rerun);
            rst_n = 1'b0;                // Async assert
        end
    end

endmodule

`default_nettype wire
